// File: common/tcls_pkg.sv
/* Shared constants, vector types, recovery state encoding and register map
   of the triple-lane lockstep checker */
package tcls_pkg;

  // Lane count and stream geometry
  localparam int unsigned NumLanes  = 3;
  localparam int unsigned WordWidth = 32;
  localparam int unsigned AddrStep  = 4;

  typedef logic [WordWidth-1:0] word_t;
  typedef logic [31:0]          addr_t;
  typedef logic [NumLanes-1:0]  lane_vec_t;
  typedef logic [15:0]          cnt_t;
  typedef logic [7:0]           axi_addr_t;
  typedef logic [1:0]           axi_resp_t;

  // Recovery state of the lockstep manager
  typedef enum logic [1:0] {
    TMR_RUN    = 2'd0,
    TMR_UNLOAD = 2'd1,
    TMR_RELOAD = 2'd2
  } red_mode_e;

  // Register byte offsets
  localparam axi_addr_t RegMode       = 8'h00;
  localparam axi_addr_t RegStatus     = 8'h04;
  localparam axi_addr_t RegMismatch0  = 8'h08;
  localparam axi_addr_t RegMismatch1  = 8'h0C;
  localparam axi_addr_t RegMismatch2  = 8'h10;
  localparam axi_addr_t RegResync     = 8'h14;
  localparam axi_addr_t RegInject     = 8'h18;
  localparam axi_addr_t RegInjectLane = 8'h1C;

  // AXI response codes
  localparam axi_resp_t RespOkay   = 2'd0;
  localparam axi_resp_t RespSlvErr = 2'd2;

endpackage

// File: verilog/tcls_fanout.sv
/* Single-word input buffer broadcasting to all lockstep lanes,
   with a one-shot XOR fault injector on one selected lane */
`timescale 1ns/1ps

module tcls_fanout import tcls_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      in_valid_i,
  input  word_t                     in_data_i,
  output logic                      in_ready_o,
  input  logic                      stall_i,
  input  logic                      step_ok_i,
  input  logic                      inj_arm_i,
  input  logic [1:0]                inj_lane_i,
  input  word_t                     inj_mask_i,
  output logic                      lane_valid_o,
  output logic                      lane_step_o,
  output word_t [NumLanes-1:0]      lane_data_o
);

  logic       buf_valid_q;
  word_t      buf_data_q;
  logic       inj_pend_q;
  logic [1:0] inj_lane_q;
  word_t      inj_mask_q;

  // Lanes only advance while the manager is running
  assign lane_valid_o = buf_valid_q;
  assign lane_step_o  = buf_valid_q & step_ok_i & ~stall_i;
  assign in_ready_o   = (~buf_valid_q | lane_step_o) & ~stall_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
      inj_pend_q  <= 1'b0;
    end else begin
      if (in_valid_i && in_ready_o) begin
        buf_valid_q <= 1'b1;
      end else if (lane_step_o) begin
        buf_valid_q <= 1'b0;
      end
      // A new arm overrides the clear of a step in the same cycle
      if (lane_step_o) begin
        inj_pend_q <= 1'b0;
      end
      if (inj_arm_i) begin
        inj_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      buf_data_q <= in_data_i;
    end
    if (inj_arm_i) begin
      inj_lane_q <= inj_lane_i;
      inj_mask_q <= inj_mask_i;
    end
  end

  for (genvar i = 0; i < NumLanes; i++) begin : g_lane_data
    assign lane_data_o[i] = (inj_pend_q && inj_lane_q == i) ? (buf_data_q ^ inj_mask_q)
                                                             : buf_data_q;
  end

endmodule

// File: lane/tcls_lane.sv
/* One lockstep lane with rotate-XOR signature accumulator,
   address counter and a single result register */
`timescale 1ns/1ps

module tcls_lane import tcls_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  step_i,
  input  word_t data_i,
  input  logic  pop_i,
  input  logic  reload_i,
  input  addr_t reload_addr_i,
  input  word_t reload_acc_i,
  output logic  res_valid_o,
  output addr_t res_addr_o,
  output word_t res_acc_o
);

  word_t acc_q;
  addr_t addr_q;
  word_t acc_next;
  logic  res_valid_q;
  addr_t res_addr_q;
  word_t res_acc_q;

  // Rotate left by one, then fold in the new word
  assign acc_next = {acc_q[WordWidth-2:0], acc_q[WordWidth-1]} ^ data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      addr_q      <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (reload_i) begin
        // Resume right after the last voted beat
        acc_q  <= reload_acc_i;
        addr_q <= reload_addr_i + AddrStep;
      end else if (step_i) begin
        acc_q  <= acc_next;
        addr_q <= addr_q + AddrStep;
      end
      if (step_i) begin
        res_valid_q <= 1'b1;
      end else if (pop_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  // Result payload keeps its last value after a pop, reload reads it back
  always_ff @(posedge clk_i) begin
    if (step_i) begin
      res_addr_q <= addr_q;
      res_acc_q  <= acc_next;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_addr_o  = res_addr_q;
  assign res_acc_o   = res_acc_q;

endmodule

// File: verilog/tcls_voter.sv
/* Bitwise two-of-three majority voter with per-lane disagreement flags */
`timescale 1ns/1ps

module tcls_voter import tcls_pkg::*; (
  input  lane_vec_t            valid_i,
  input  addr_t [NumLanes-1:0] addr_i,
  input  word_t [NumLanes-1:0] acc_i,
  output logic                 valid_o,
  output addr_t                addr_o,
  output word_t                acc_o,
  output lane_vec_t            err_lanes_o
);

  // Each bit takes the value held by at least two lanes
  assign valid_o = (valid_i[0] & valid_i[1]) |
                   (valid_i[0] & valid_i[2]) |
                   (valid_i[1] & valid_i[2]);

  assign addr_o = (addr_i[0] & addr_i[1]) |
                  (addr_i[0] & addr_i[2]) |
                  (addr_i[1] & addr_i[2]);

  assign acc_o = (acc_i[0] & acc_i[1]) |
                 (acc_i[0] & acc_i[2]) |
                 (acc_i[1] & acc_i[2]);

  // A lane is flagged as soon as one of its bits leaves the majority
  for (genvar i = 0; i < NumLanes; i++) begin : g_err
    assign err_lanes_o[i] = (valid_i[i] != valid_o) |
                            (addr_i[i] != addr_o) |
                            (acc_i[i] != acc_o);
  end

endmodule

// File: manager/tcls_manager.sv
/* Lockstep manager with run/unload/reload recovery FSM, output drain,
   mismatch classification and saturating per-lane counters */
`timescale 1ns/1ps

module tcls_manager import tcls_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      voted_valid_i,
  input  addr_t     voted_addr_i,
  input  word_t     voted_acc_i,
  input  lane_vec_t err_lanes_i,
  output logic      out_valid_o,
  output addr_t     out_addr_o,
  output word_t     out_data_o,
  input  logic      out_ready_i,
  output logic      res_pop_o,
  output logic      reload_o,
  output logic      stall_o,
  input  logic      restore_mode_i,
  input  logic      resync_req_i,
  output red_mode_e state_o,
  output cnt_t      cnt0_o,
  output cnt_t      cnt1_o,
  output cnt_t      cnt2_o,
  output logic      mismatch_o,
  output logic      multi_mismatch_o
);

  red_mode_e            state_q, state_d;
  logic                 running;
  logic                 pop;
  logic                 single_lane;
  logic                 enter_unload;
  lane_vec_t            err_rest;
  cnt_t [NumLanes-1:0]  cnt_q;

  assign running = (state_q == TMR_RUN);
  assign pop     = running & voted_valid_i & out_ready_i;

  // Output stream is gated outside of normal running
  assign out_valid_o = running & voted_valid_i;
  assign out_addr_o  = voted_addr_i;
  assign out_data_o  = voted_acc_i;
  assign res_pop_o   = pop;

  // Clearing the lowest set bit leaves nothing when only one lane differs
  assign err_rest         = err_lanes_i & (err_lanes_i - lane_vec_t'(1));
  assign single_lane      = (err_rest == '0);
  assign mismatch_o       = pop & (err_lanes_i != '0);
  assign multi_mismatch_o = mismatch_o & ~single_lane;

  // Freeze the lanes already in the pop cycle so the voted state survives
  assign enter_unload = mismatch_o & ~restore_mode_i;
  assign stall_o      = ~running | enter_unload;
  assign reload_o     = (state_q == TMR_RELOAD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      TMR_RUN: begin
        if (enter_unload) begin
          state_d = TMR_UNLOAD;
        end
      end
      TMR_UNLOAD: begin
        if (resync_req_i) begin
          state_d = TMR_RELOAD;
        end
      end
      TMR_RELOAD: state_d = TMR_RUN;
      default:    state_d = TMR_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TMR_RUN;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (mismatch_o && single_lane) begin
        for (int i = 0; i < NumLanes; i++) begin
          if (err_lanes_i[i] && cnt_q[i] != '1) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
          end
        end
      end
    end
  end

  assign state_o = state_q;
  assign cnt0_o  = cnt_q[0];
  assign cnt1_o  = cnt_q[1];
  assign cnt2_o  = cnt_q[2];

endmodule

// File: manager/tcls_axil_regs.sv
/* AXI4-Lite register slave for recovery mode, status, mismatch counters,
   resync trigger and the one-shot fault injector */
`timescale 1ns/1ps

module tcls_axil_regs import tcls_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  axi_addr_t  s_axil_awaddr_i,
  input  logic       s_axil_awvalid_i,
  output logic       s_axil_awready_o,
  input  word_t      s_axil_wdata_i,
  input  logic [3:0] s_axil_wstrb_i,
  input  logic       s_axil_wvalid_i,
  output logic       s_axil_wready_o,
  output axi_resp_t  s_axil_bresp_o,
  output logic       s_axil_bvalid_o,
  input  logic       s_axil_bready_i,
  input  axi_addr_t  s_axil_araddr_i,
  input  logic       s_axil_arvalid_i,
  output logic       s_axil_arready_o,
  output word_t      s_axil_rdata_o,
  output axi_resp_t  s_axil_rresp_o,
  output logic       s_axil_rvalid_o,
  input  logic       s_axil_rready_i,
  output logic       restore_mode_o,
  output logic       resync_req_o,
  output logic       inj_arm_o,
  output logic [1:0] inj_lane_o,
  output word_t      inj_mask_o,
  input  red_mode_e  state_i,
  input  cnt_t       cnt0_i,
  input  cnt_t       cnt1_i,
  input  cnt_t       cnt2_i
);

  logic       wr_ready_q;
  logic       bvalid_q;
  axi_resp_t  bresp_q;
  logic       ar_ready_q;
  logic       rvalid_q;
  axi_resp_t  rresp_q;
  word_t      rdata_q;
  logic       restore_mode_q;
  logic       resync_q;
  logic       inj_arm_q;
  logic [1:0] inj_lane_q;
  word_t      inj_mask_q;
  word_t      wr_merged;
  word_t      rd_data;
  logic       rd_err;

  function automatic word_t apply_strb(word_t old_val, word_t new_val, logic [3:0] strb);
    word_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_merged = apply_strb(inj_mask_q, s_axil_wdata_i, s_axil_wstrb_i);

  // Read mux
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (s_axil_araddr_i)
      RegMode:       rd_data = {31'b0, restore_mode_q};
      RegStatus:     rd_data = {30'b0, state_i};
      RegMismatch0:  rd_data = {16'b0, cnt0_i};
      RegMismatch1:  rd_data = {16'b0, cnt1_i};
      RegMismatch2:  rd_data = {16'b0, cnt2_i};
      RegResync:     rd_data = '0;
      RegInject:     rd_data = inj_mask_q;
      RegInjectLane: rd_data = {30'b0, inj_lane_q};
      default:       rd_err  = 1'b1;
    endcase
  end

  // Write channel takes AW and W together once both are presented
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ready_q     <= 1'b0;
      bvalid_q       <= 1'b0;
      bresp_q        <= RespOkay;
      restore_mode_q <= 1'b0;
      resync_q       <= 1'b0;
      inj_arm_q      <= 1'b0;
      inj_lane_q     <= '0;
      inj_mask_q     <= '0;
    end else begin
      wr_ready_q <= s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_q & ~wr_ready_q;
      resync_q   <= 1'b0;
      inj_arm_q  <= 1'b0;
      if (bvalid_q && s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (wr_ready_q) begin
        bvalid_q <= 1'b1;
        bresp_q  <= RespOkay;
        case (s_axil_awaddr_i)
          RegMode: begin
            if (s_axil_wstrb_i[0]) begin
              restore_mode_q <= s_axil_wdata_i[0];
            end
          end
          RegResync:     resync_q   <= 1'b1;
          RegInject:     inj_mask_q <= wr_merged;
          RegInjectLane: begin
            if (s_axil_wstrb_i[0]) begin
              inj_lane_q <= s_axil_wdata_i[1:0];
            end
            inj_arm_q <= 1'b1;
          end
          // Status and counters ignore writes
          RegStatus, RegMismatch0, RegMismatch1, RegMismatch2: bresp_q <= RespOkay;
          default: bresp_q <= RespSlvErr;
        endcase
      end
    end
  end

  // Read channel with a single outstanding response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_ready_q <= 1'b0;
      rvalid_q   <= 1'b0;
      rresp_q    <= RespOkay;
      rdata_q    <= '0;
    end else begin
      ar_ready_q <= s_axil_arvalid_i & ~rvalid_q & ~ar_ready_q;
      if (rvalid_q && s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (ar_ready_q) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
        rresp_q  <= rd_err ? RespSlvErr : RespOkay;
      end
    end
  end

  assign s_axil_awready_o = wr_ready_q;
  assign s_axil_wready_o  = wr_ready_q;
  assign s_axil_bvalid_o  = bvalid_q;
  assign s_axil_bresp_o   = bresp_q;
  assign s_axil_arready_o = ar_ready_q;
  assign s_axil_rvalid_o  = rvalid_q;
  assign s_axil_rdata_o   = rdata_q;
  assign s_axil_rresp_o   = rresp_q;

  assign restore_mode_o = restore_mode_q;
  assign resync_req_o   = resync_q;
  assign inj_arm_o      = inj_arm_q;
  assign inj_lane_o     = inj_lane_q;
  assign inj_mask_o     = inj_mask_q;

endmodule

// File: verilog/tcls_top.sv
/* Triple-lane lockstep checker top with fan-out, generated lanes, voter,
   recovery manager and AXI4-Lite registers */
`timescale 1ns/1ps

module tcls_top import tcls_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       in_valid_i,
  input  word_t      in_data_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  output addr_t      out_addr_o,
  output word_t      out_data_o,
  input  logic       out_ready_i,
  input  axi_addr_t  s_axil_awaddr_i,
  input  logic       s_axil_awvalid_i,
  output logic       s_axil_awready_o,
  input  word_t      s_axil_wdata_i,
  input  logic [3:0] s_axil_wstrb_i,
  input  logic       s_axil_wvalid_i,
  output logic       s_axil_wready_o,
  output axi_resp_t  s_axil_bresp_o,
  output logic       s_axil_bvalid_o,
  input  logic       s_axil_bready_i,
  input  axi_addr_t  s_axil_araddr_i,
  input  logic       s_axil_arvalid_i,
  output logic       s_axil_arready_o,
  output word_t      s_axil_rdata_o,
  output axi_resp_t  s_axil_rresp_o,
  output logic       s_axil_rvalid_o,
  input  logic       s_axil_rready_i,
  output logic       mismatch_o,
  output logic       multi_mismatch_o
);

  logic                 lane_step;
  word_t [NumLanes-1:0] lane_data;
  lane_vec_t            res_valid;
  addr_t [NumLanes-1:0] res_addr;
  word_t [NumLanes-1:0] res_acc;
  logic                 voted_valid;
  addr_t                voted_addr;
  word_t                voted_acc;
  lane_vec_t            err_lanes;
  logic                 res_pop, reload, stall, step_ok;
  logic                 restore_mode, resync_req, inj_arm;
  logic [1:0]           inj_lane;
  word_t                inj_mask;
  red_mode_e            state;
  cnt_t                 cnt0, cnt1, cnt2;

  // Lane result registers are empty or drained this cycle
  assign step_ok = ~voted_valid | res_pop;

  tcls_fanout i_fanout (
    .clk_i, .rst_ni, .in_valid_i, .in_data_i, .in_ready_o,
    .stall_i (stall), .step_ok_i (step_ok),
    .inj_arm_i (inj_arm), .inj_lane_i (inj_lane), .inj_mask_i (inj_mask),
    .lane_valid_o (), .lane_step_o (lane_step), .lane_data_o (lane_data)
  );

  for (genvar i = 0; i < NumLanes; i++) begin : g_lane
    tcls_lane i_lane (
      .clk_i, .rst_ni, .step_i (lane_step), .data_i (lane_data[i]),
      .pop_i (res_pop), .reload_i (reload),
      .reload_addr_i (voted_addr), .reload_acc_i (voted_acc),
      .res_valid_o (res_valid[i]), .res_addr_o (res_addr[i]), .res_acc_o (res_acc[i])
    );
  end

  tcls_voter i_voter (
    .valid_i (res_valid), .addr_i (res_addr), .acc_i (res_acc),
    .valid_o (voted_valid), .addr_o (voted_addr), .acc_o (voted_acc),
    .err_lanes_o (err_lanes)
  );

  tcls_manager i_manager (
    .clk_i, .rst_ni,
    .voted_valid_i (voted_valid), .voted_addr_i (voted_addr),
    .voted_acc_i (voted_acc), .err_lanes_i (err_lanes),
    .out_valid_o, .out_addr_o, .out_data_o, .out_ready_i,
    .res_pop_o (res_pop), .reload_o (reload), .stall_o (stall),
    .restore_mode_i (restore_mode), .resync_req_i (resync_req), .state_o (state),
    .cnt0_o (cnt0), .cnt1_o (cnt1), .cnt2_o (cnt2),
    .mismatch_o, .multi_mismatch_o
  );

  tcls_axil_regs i_regs (
    .clk_i, .rst_ni,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .restore_mode_o (restore_mode), .resync_req_o (resync_req),
    .inj_arm_o (inj_arm), .inj_lane_o (inj_lane), .inj_mask_o (inj_mask),
    .state_i (state), .cnt0_i (cnt0), .cnt1_i (cnt1), .cnt2_i (cnt2)
  );

endmodule

// File: verification/tcls_tb_tasks.svh
/* AXI4-Lite read/write tasks, stream driver, drain and state polling helpers
   shared by the lockstep checker testbench */
`ifndef TCLS_TB_TASKS_SVH
`define TCLS_TB_TASKS_SVH

task automatic report_timeout(input string what);
  other_errors++;
  $display("Timeout while waiting for %s", what);
endtask

task automatic axi_write(input axi_addr_t addr, input word_t data, output axi_resp_t resp);
  int   waited;
  logic done;
  @(negedge clk_i);
  s_axil_awaddr_i  = addr;
  s_axil_awvalid_i = 1'b1;
  s_axil_wdata_i   = data;
  s_axil_wstrb_i   = 4'hF;
  s_axil_wvalid_i  = 1'b1;
  s_axil_bready_i  = 1'b1;
  done   = 1'b0;
  waited = 0;
  while (!done && waited < WaitLimit) begin
    @(posedge clk_i);
    done = s_axil_awready_o && s_axil_wready_o;
    waited++;
  end
  if (!done) report_timeout("the AXI write address and data handshake");
  @(negedge clk_i);
  s_axil_awvalid_i = 1'b0;
  s_axil_wvalid_i  = 1'b0;
  done   = 1'b0;
  waited = 0;
  resp   = RespSlvErr;
  while (!done && waited < WaitLimit) begin
    @(posedge clk_i);
    done = s_axil_bvalid_o;
    resp = s_axil_bresp_o;
    waited++;
  end
  if (!done) report_timeout("the AXI write response");
  @(negedge clk_i);
  s_axil_bready_i = 1'b0;
endtask

task automatic axi_read(input axi_addr_t addr, output word_t data, output axi_resp_t resp);
  int   waited;
  logic done;
  @(negedge clk_i);
  s_axil_araddr_i  = addr;
  s_axil_arvalid_i = 1'b1;
  s_axil_rready_i  = 1'b1;
  done   = 1'b0;
  waited = 0;
  while (!done && waited < WaitLimit) begin
    @(posedge clk_i);
    done = s_axil_arready_o;
    waited++;
  end
  if (!done) report_timeout("the AXI read address handshake");
  @(negedge clk_i);
  s_axil_arvalid_i = 1'b0;
  done   = 1'b0;
  waited = 0;
  data   = '0;
  resp   = RespSlvErr;
  while (!done && waited < WaitLimit) begin
    @(posedge clk_i);
    done = s_axil_rvalid_o;
    data = s_axil_rdata_o;
    resp = s_axil_rresp_o;
    waited++;
  end
  if (!done) report_timeout("the AXI read data");
  @(negedge clk_i);
  s_axil_rready_i = 1'b0;
endtask

task automatic write_reg(input axi_addr_t addr, input word_t data);
  axi_resp_t resp;
  axi_write(addr, data, resp);
  assert (resp == RespOkay) else begin
    mismatch_errors++;
    $display("Mismatch bresp at 0x%h: got 0x%h, expected 0x%h", addr, resp, RespOkay);
  end
endtask

task automatic read_check(input axi_addr_t addr, input word_t expected, input string name);
  word_t     data;
  axi_resp_t resp;
  axi_read(addr, data, resp);
  assert (resp == RespOkay && data == expected) else begin
    mismatch_errors++;
    $display("Mismatch %s: got 0x%h (rresp 0x%h), expected 0x%h", name, data, resp, expected);
  end
endtask

// Words back to back as far as in_ready_o allows
task automatic send_words(input int count);
  int   waited;
  logic taken;
  for (int i = 0; i < count; i++) begin
    @(negedge clk_i);
    in_valid_i = 1'b1;
    in_data_i  = $urandom();
    taken  = 1'b0;
    waited = 0;
    while (!taken && waited < WaitLimit) begin
      @(posedge clk_i);
      taken = in_ready_o;
      waited++;
    end
    if (!taken) report_timeout("in_ready_o");
  end
  @(negedge clk_i);
  in_valid_i = 1'b0;
endtask

task automatic wait_drain();
  int waited;
  waited = 0;
  while (exp_word_q.size() != 0 && waited < WaitLimit) begin
    @(posedge clk_i);
    waited++;
  end
  if (exp_word_q.size() != 0) report_timeout("the output stream to drain");
endtask

task automatic wait_status(input red_mode_e target);
  word_t     data;
  axi_resp_t resp;
  int        tries;
  tries = 0;
  data  = '1;
  while (data[1:0] != target && tries < WaitLimit) begin
    axi_read(RegStatus, data, resp);
    tries++;
  end
  if (data[1:0] != target) report_timeout({"state ", target.name()});
endtask

task automatic drive_out_ready();
  forever begin
    @(negedge clk_i);
    out_ready_i = ready_random ? ($urandom_range(3) != 0) : 1'b1;
  end
endtask

`endif

// File: verification/tcls_tb.sv
/* Testbench for the lockstep checker with a three-lane reference model,
   stream and register stimulus, and assertion checks */
`timescale 1ns/1ps

module tcls_tb import tcls_pkg::*; ();

  localparam int WaitLimit = 200;

  logic       clk_i, rst_ni;
  logic       in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  word_t      in_data_i, out_data_o;
  addr_t      out_addr_o;
  axi_addr_t  s_axil_awaddr_i, s_axil_araddr_i;
  logic       s_axil_awvalid_i, s_axil_awready_o, s_axil_wvalid_i, s_axil_wready_o;
  word_t      s_axil_wdata_i, s_axil_rdata_o;
  logic [3:0] s_axil_wstrb_i;
  axi_resp_t  s_axil_bresp_o, s_axil_rresp_o;
  logic       s_axil_bvalid_o, s_axil_bready_i, s_axil_arvalid_i, s_axil_arready_o;
  logic       s_axil_rvalid_o, s_axil_rready_i;
  logic       mismatch_o, multi_mismatch_o;

  int         mismatch_errors = 0;
  int         other_errors = 0;
  // Accepted words wait here with the fault they carry until their beat pops
  word_t      exp_word_q[$];
  int         exp_lane_q[$];
  word_t      exp_mask_q[$];
  int         pend_lane = -1;
  word_t      pend_mask;
  word_t      golden_acc;
  word_t      lane_acc[NumLanes];
  addr_t      exp_addr;
  int         exp_cnt[NumLanes];
  int         multi_seen = 0;
  logic       ready_random = 1'b0;
  logic       hold_pending = 1'b0;
  addr_t      hold_addr;
  word_t      hold_data;

  tcls_top dut (.*);

  `include "tcls_tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic word_t rotl1(word_t v);
    return {v[WordWidth-2:0], v[WordWidth-1]};
  endfunction

  function automatic word_t majority3(word_t a, word_t b, word_t c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  task automatic check_beat();
    word_t     w, m, voted;
    int        il;
    lane_vec_t errv;
    if (exp_word_q.size() == 0) begin
      other_errors++;
      $display("Output beat arrived with no accepted word pending");
      return;
    end
    w  = exp_word_q.pop_front();
    il = exp_lane_q.pop_front();
    m  = exp_mask_q.pop_front();
    golden_acc = rotl1(golden_acc) ^ w;
    for (int l = 0; l < NumLanes; l++) begin
      lane_acc[l] = rotl1(lane_acc[l]) ^ ((l == il) ? (w ^ m) : w);
    end
    voted = majority3(lane_acc[0], lane_acc[1], lane_acc[2]);
    for (int l = 0; l < NumLanes; l++) begin
      errv[l] = (lane_acc[l] != voted);
    end
    assert (out_addr_o == exp_addr) else begin
      mismatch_errors++;
      $display("Mismatch out_addr_o: got 0x%h, expected 0x%h", out_addr_o, exp_addr);
    end
    assert (out_data_o == golden_acc) else begin
      mismatch_errors++;
      $display("Mismatch out_data_o: got 0x%h, expected 0x%h", out_data_o, golden_acc);
    end
    assert (mismatch_o == (errv != '0)) else begin
      mismatch_errors++;
      $display("Mismatch mismatch_o: got 0x%h, expected 0x%h", mismatch_o, errv != '0);
    end
    assert (multi_mismatch_o == ($countones(errv) > 1)) else begin
      mismatch_errors++;
      $display("Mismatch multi_mismatch_o: got 0x%h, expected 0x%h", multi_mismatch_o,
               $countones(errv) > 1);
    end
    if ($countones(errv) == 1) begin
      for (int l = 0; l < NumLanes; l++) begin
        if (errv[l]) exp_cnt[l]++;
      end
    end
    if (multi_mismatch_o) multi_seen++;
    exp_addr += AddrStep;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (in_valid_i && in_ready_o) begin
        exp_word_q.push_back(in_data_i);
        exp_lane_q.push_back(pend_lane);
        exp_mask_q.push_back(pend_mask);
        pend_lane = -1;
      end
      if (hold_pending) begin
        assert (out_valid_o) else begin
          other_errors++;
          $display("out_valid_o dropped before the beat was taken");
        end
        assert (out_data_o == hold_data) else begin
          mismatch_errors++;
          $display("Mismatch out_data_o: got 0x%h, expected held 0x%h", out_data_o, hold_data);
        end
        assert (out_addr_o == hold_addr) else begin
          mismatch_errors++;
          $display("Mismatch out_addr_o: got 0x%h, expected held 0x%h", out_addr_o, hold_addr);
        end
      end
      if (out_valid_o && out_ready_i) check_beat();
      hold_pending = out_valid_o && !out_ready_i;
      hold_addr    = out_addr_o;
      hold_data    = out_data_o;
    end
  end

  unload_gates_streams: assert property (@(posedge clk_i) disable iff (!rst_ni)
      dut.state == TMR_UNLOAD |-> !out_valid_o && !in_ready_o)
    else begin
      other_errors++;
      $display("A stream stayed open while the manager was unloading");
    end

  multi_keeps_counters: assert property (@(posedge clk_i) disable iff (!rst_ni)
      multi_mismatch_o |=> $stable(dut.cnt0) && $stable(dut.cnt1) && $stable(dut.cnt2))
    else begin
      other_errors++;
      $display("A mismatch counter moved on a multi-lane mismatch beat");
    end

  // Next accepted word is the next stepped one, since the pipeline is idle here
  task automatic inject(input int lane, input word_t mask);
    write_reg(RegInject, mask);
    write_reg(RegInjectLane, word_t'(lane));
    pend_lane = lane;
    pend_mask = mask;
  endtask

  task automatic stop_and_resync();
    wait_status(TMR_UNLOAD);
    repeat (10) @(posedge clk_i);
    read_check(RegStatus, TMR_UNLOAD, "RegStatus");
    // Reload copies the voted state into every lane
    for (int l = 0; l < NumLanes; l++) lane_acc[l] = golden_acc;
    write_reg(RegResync, 32'h1);
    wait_status(TMR_RUN);
  endtask

  task automatic check_counters();
    read_check(RegMismatch0, exp_cnt[0], "RegMismatch0");
    read_check(RegMismatch1, exp_cnt[1], "RegMismatch1");
    read_check(RegMismatch2, exp_cnt[2], "RegMismatch2");
  endtask

  initial begin
    word_t     rdata;
    axi_resp_t resp;
    rst_ni = 1'b0;
    in_valid_i = 1'b0;
    in_data_i = '0;
    out_ready_i = 1'b0;
    s_axil_awaddr_i = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i = '0;
    s_axil_wstrb_i = '0;
    s_axil_wvalid_i = 1'b0;
    s_axil_bready_i = 1'b0;
    s_axil_araddr_i = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i = 1'b0;
    golden_acc = '0;
    exp_addr = '0;
    pend_mask = '0;
    for (int l = 0; l < NumLanes; l++) begin
      lane_acc[l] = '0;
      exp_cnt[l]  = 0;
    end
    void'($urandom(31));
    fork
      drive_out_ready();
    join_none
    repeat (8) @(posedge clk_i);
    assert (!out_valid_o && !mismatch_o && !multi_mismatch_o && !dut.reload &&
            !s_axil_awready_o && !s_axil_wready_o && !s_axil_bvalid_o &&
            !s_axil_arready_o && !s_axil_rvalid_o && dut.state == TMR_RUN) else begin
      other_errors++;
      $display("DUT outputs are not idle during reset");
    end
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Normal stream under random back-pressure
    ready_random = 1'b1;
    send_words(40);
    wait_drain();

    // Lane 1 fault masked by the majority
    write_reg(RegMode, 32'h1);
    send_words(5);
    wait_drain();
    inject(1, 32'h0000_0100);
    send_words(12);
    wait_drain();
    read_check(RegMismatch0, 32'd0, "RegMismatch0");
    read_check(RegMismatch1, 32'd12, "RegMismatch1");
    read_check(RegMismatch2, 32'd0, "RegMismatch2");

    // Lane 1 still diverges, so a stop and resync clears it first
    write_reg(RegMode, 32'h0);
    send_words(1);
    stop_and_resync();
    wait_drain();

    // Stop on a lane 2 fault, then resync
    send_words(3);
    wait_drain();
    inject(2, 32'h8000_0001);
    send_words(2);
    wait_status(TMR_UNLOAD);
    assert (exp_word_q.size() == 1) else begin
      other_errors++;
      $display("Expected one word held back during unload, found %0d", exp_word_q.size());
    end
    stop_and_resync();
    wait_drain();
    send_words(6);
    wait_drain();
    read_check(RegMismatch2, 32'd1, "RegMismatch2");
    check_counters();

    // Two lanes hit on consecutive words with disjoint masks
    write_reg(RegMode, 32'h1);
    inject(0, 32'h0000_0001);
    send_words(1);
    wait_drain();
    inject(2, 32'h0001_0000);
    send_words(8);
    wait_drain();
    assert (multi_seen > 0) else begin
      other_errors++;
      $display("No multi-lane mismatch beat was seen");
    end
    check_counters();

    // Register map
    write_reg(RegMode, 32'h0);
    read_check(RegMode, 32'h0, "RegMode");
    write_reg(RegMode, 32'h1);
    read_check(RegMode, 32'h1, "RegMode");
    axi_write(8'h40, 32'hDEAD_BEEF, resp);
    assert (resp == RespSlvErr) else begin
      mismatch_errors++;
      $display("Mismatch bresp: got 0x%h, expected 0x%h", resp, RespSlvErr);
    end
    axi_read(8'h40, rdata, resp);
    assert (resp == RespSlvErr && rdata == '0) else begin
      mismatch_errors++;
      $display("Mismatch rresp/rdata: got 0x%h/0x%h, expected 0x%h/0x0", resp, rdata, RespSlvErr);
    end

    $display("Run finished with %0d mismatches and %0d other errors",
             mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verification
common/tcls_pkg.sv
verilog/tcls_fanout.sv
lane/tcls_lane.sv
verilog/tcls_voter.sv
manager/tcls_manager.sv
manager/tcls_axil_regs.sv
verilog/tcls_top.sv
verification/tcls_tb.sv
